//--- rtl/ctr_pkg.sv
/*
  Counter geometry is fixed at 128 bits in eight 16-bit slices.
  Other widths need a new ctr_word_u, not just new constants.
  Rail codes 00 and 11 are faults and never mean idle.
*/
package ctr_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  parameter int unsigned CtrWidth      = 128;
  parameter int unsigned SliceSizeCtr  = 16;
  parameter int unsigned NumSlices     = CtrWidth / SliceSizeCtr;
  parameter int unsigned SliceIdxWidth = 3;

  // Counter word, seen whole or as slices
  // Slice 0 holds the least significant bits
  typedef union packed {
    logic [CtrWidth-1:0]                     flat;
    logic [NumSlices-1:0][SliceSizeCtr-1:0]  slice;
  } ctr_word_u;

  ////////////////////
  // Two-rail codes
  ////////////////////

  parameter logic [1:0] MrOn  = 2'b10;
  parameter logic [1:0] MrOff = 2'b01;

  ////////////////////
  // FSM states
  ////////////////////

  // Pairwise Hamming distance of at least 3
  typedef enum logic [5:0] {
    CTR_IDLE  = 6'b011010,
    CTR_INCR  = 6'b101101,
    CTR_ERROR = 6'b110011
  } ctr_state_e;

endpackage

//--- rtl/ctr_req_check.sv
/*
  Requests are plain levels, sampled only while ready_i is high.
  Busy requests are flagged as faults and never queued.
*/
module ctr_req_check (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [1:0] incr_mr_i,
  input  logic       load_i,
  input  logic       ready_i,
  output logic       incr_o,
  output logic       mr_err_o,
  output logic       seq_err_o
);

  logic incr_req;
  logic mr_bad;
  logic mr_err_q;

  // Decode the two-rail level
  assign incr_req = (incr_mr_i == ctr_pkg::MrOn);
  assign mr_bad   = (incr_mr_i != ctr_pkg::MrOn) && (incr_mr_i != ctr_pkg::MrOff);

  // Only accepted while idle
  assign incr_o = incr_req && ready_i;

  // Hold a rail fault for one extra cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mr_err_q <= 1'b0;
    end else begin
      mr_err_q <= mr_bad;
    end
  end

  // Seen now or in the cycle before
  assign mr_err_o = mr_bad || mr_err_q;

  // Request while busy, or load and increment together
  assign seq_err_o = ((incr_req || load_i) && !ready_i) || (incr_req && load_i);

  ////////////////////
  // Assertions
  ////////////////////

  // An accepted increment has a clean rail code now and one cycle back
  IncrValidCode_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    incr_o |-> !mr_err_o);

endmodule

//--- rtl/ctr_fsm.sv
/*
  Increments one 16-bit slice per cycle, lowest slice first.
  Latency is fixed at 8 cycles since every slice is written.
  CTR_ERROR is terminal and only reset leaves it.
*/
module ctr_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              incr_i,
  input  logic                              incr_err_i,
  input  logic                              mr_err_i,
  input  logic [ctr_pkg::SliceSizeCtr-1:0]  ctr_slice_i,
  output logic                              ready_o,
  output logic                              alert_o,
  output logic [ctr_pkg::SliceIdxWidth-1:0] ctr_slice_idx_o,
  output logic [ctr_pkg::SliceSizeCtr-1:0]  ctr_slice_o,
  output logic                              ctr_we_o
);

  localparam logic [ctr_pkg::SliceIdxWidth-1:0] IdxOne =
    {{(ctr_pkg::SliceIdxWidth-1){1'b0}}, 1'b1};
  localparam logic [ctr_pkg::SliceIdxWidth-1:0] IdxLast =
    {ctr_pkg::SliceIdxWidth{1'b1}};

  ctr_pkg::ctr_state_e               state_d, state_q;
  logic [ctr_pkg::SliceIdxWidth-1:0] idx_d, idx_q;
  logic                              carry_d, carry_q;

  // One extra bit for the carry out
  logic [ctr_pkg::SliceSizeCtr:0]    ctr_value;

  ////////////////////
  // Slice adder
  ////////////////////

  assign ctr_value = {1'b0, ctr_slice_i} + {{ctr_pkg::SliceSizeCtr{1'b0}}, carry_q};
  assign ctr_slice_o = ctr_value[ctr_pkg::SliceSizeCtr-1:0];

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    // Defaults
    ready_o  = 1'b0;
    ctr_we_o = 1'b0;
    alert_o  = 1'b0;
    state_d  = state_q;
    idx_d    = idx_q;
    carry_d  = carry_q;

    case (state_q)
      ctr_pkg::CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at slice 0 with a carry in of one
          idx_d   = '0;
          carry_d = 1'b1;
          state_d = ctr_pkg::CTR_INCR;
        end
      end

      ctr_pkg::CTR_INCR: begin
        ctr_we_o = 1'b1;
        idx_d    = idx_q + IdxOne;
        carry_d  = ctr_value[ctr_pkg::SliceSizeCtr];
        // Top slice written this cycle
        if (idx_q == IdxLast) begin
          state_d = ctr_pkg::CTR_IDLE;
        end
      end

      ctr_pkg::CTR_ERROR: begin
        // Terminal
        alert_o = 1'b1;
      end

      default: begin
        // Unlisted encoding, treat as an attack
        alert_o = 1'b1;
        state_d = ctr_pkg::CTR_ERROR;
      end
    endcase

    // Any fault wins over normal flow
    if (incr_err_i || mr_err_i) begin
      state_d = ctr_pkg::CTR_ERROR;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ctr_pkg::CTR_IDLE;
      idx_q   <= '0;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
      carry_q <= carry_d;
    end
  end

  assign ctr_slice_idx_o = idx_q;

  ////////////////////
  // Assertions
  ////////////////////

  // Alert is terminal and keeps ready low
  AlertSticky_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> (alert_o && !ready_o));

  // Every increment starts writing at slice 0
  WriteStart_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ctr_we_o) |-> (ctr_slice_idx_o == '0));

endmodule

//--- rtl/ctr_state_reg.sv
/*
  A load takes priority over a slice write in the same cycle.
  Loads are taken even in a fault, so the alert marks the value invalid.
*/
module ctr_state_reg (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              load_i,
  input  ctr_pkg::ctr_word_u                iv_i,
  input  logic [ctr_pkg::SliceIdxWidth-1:0] slice_idx_i,
  input  logic [ctr_pkg::SliceSizeCtr-1:0]  slice_i,
  input  logic                              slice_we_i,
  output logic [ctr_pkg::SliceSizeCtr-1:0]  slice_o,
  output ctr_pkg::ctr_word_u                ctr_o
);

  ctr_pkg::ctr_word_u ctr_q;

  ////////////////////
  // Counter storage
  ////////////////////

  // Counter starts at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q.flat <= '0;
    end else if (load_i) begin
      // Whole word from the IV
      ctr_q.flat <= iv_i.flat;
    end else if (slice_we_i) begin
      // Just the slice being incremented
      ctr_q.slice[slice_idx_i] <= slice_i;
    end
  end

  ////////////////////
  // Read side
  ////////////////////

  // Slice feeding the FSM adder
  assign slice_o = ctr_q.slice[slice_idx_i];

  // Full counter out
  assign ctr_o = ctr_q;

  ////////////////////
  // Assertions
  ////////////////////

  // Legal use never loads during an increment
  LoadNoWrite_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_i |-> !slice_we_i);

endmodule

//--- rtl/ctr_top.sv
/*
  ready_o is high when idle, alert_o is sticky until reset.
  Requests while ready_o is low are faults and are not queued.
*/
module ctr_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [1:0]         incr_mr_i,
  input  logic               load_i,
  input  ctr_pkg::ctr_word_u iv_i,
  output ctr_pkg::ctr_word_u ctr_o,
  output logic               ready_o,
  output logic               alert_o
);

  // Checker to FSM
  logic incr;
  logic mr_err;
  logic seq_err;

  // FSM to register and back
  logic [ctr_pkg::SliceIdxWidth-1:0] ctr_slice_idx;
  logic [ctr_pkg::SliceSizeCtr-1:0]  ctr_slice;
  logic [ctr_pkg::SliceSizeCtr-1:0]  ctr_slice_cur;
  logic                              ctr_we;

  ////////////////////
  // Request check
  ////////////////////

  ctr_req_check u_req_check (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .incr_mr_i (incr_mr_i),
    .load_i    (load_i),
    .ready_i   (ready_o),
    .incr_o    (incr),
    .mr_err_o  (mr_err),
    .seq_err_o (seq_err)
  );

  ////////////////////
  // Control
  ////////////////////

  ctr_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .incr_i          (incr),
    .incr_err_i      (seq_err),
    .mr_err_i        (mr_err),
    .ctr_slice_i     (ctr_slice_cur),
    .ready_o         (ready_o),
    .alert_o         (alert_o),
    .ctr_slice_idx_o (ctr_slice_idx),
    .ctr_slice_o     (ctr_slice),
    .ctr_we_o        (ctr_we)
  );

  ////////////////////
  // Counter word
  ////////////////////

  ctr_state_reg u_state_reg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (load_i),
    .iv_i        (iv_i),
    .slice_idx_i (ctr_slice_idx),
    .slice_i     (ctr_slice),
    .slice_we_i  (ctr_we),
    .slice_o     (ctr_slice_cur),
    .ctr_o       (ctr_o)
  );

endmodule

//--- tb/tb_ctr_top.sv
/*
  Directed tests for the counter block, inputs driven 1 ns after the edge.
  Outputs are sampled on the falling edge. Stops at the first error.
*/
module tb_ctr_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ReadyTimeout = 20;
  localparam int IncrCycles   = 8;

  logic               clk_i;
  logic               rst_ni;
  logic [1:0]         incr_mr_i;
  logic               load_i;
  ctr_pkg::ctr_word_u iv_i;
  ctr_pkg::ctr_word_u ctr_o;
  logic               ready_o;
  logic               alert_o;
  integer             seed;

  // Counter value the model expects
  ctr_pkg::ctr_word_u model_ctr;

  ctr_top DUT (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .incr_mr_i (incr_mr_i),
    .load_i    (load_i),
    .iv_i      (iv_i),
    .ctr_o     (ctr_o),
    .ready_o   (ready_o),
    .alert_o   (alert_o)
  );

  // 4 ns clock
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input ctr_pkg::ctr_word_u got,
                            input ctr_pkg::ctr_word_u exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %s got %h exp %h", name, got.flat, exp.flat));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %s got %h exp %h", name, got, exp));
    end
  endtask

  // Reference model, counter plus one modulo 2^128
  function automatic ctr_pkg::ctr_word_u model_incr(input ctr_pkg::ctr_word_u v);
    ctr_pkg::ctr_word_u r;
    r.flat = v.flat + 128'd1;
    return r;
  endfunction

  task automatic rand_word(output ctr_pkg::ctr_word_u r);
    int i;
    for (i = 0; i < 4; i++) begin
      r.flat[32*i +: 32] = $random(seed);
    end
  endtask

  task automatic reset_dut();
    rst_ni    = 1'b0;
    incr_mr_i = ctr_pkg::MrOff;
    load_i    = 1'b0;
    model_ctr.flat = '0;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
  endtask

  // Counts falling edges with ready_o low, bounded
  task automatic wait_ready(output int cycles);
    cycles = 0;
    @(negedge clk_i);
    while (!ready_o) begin
      if (cycles >= ReadyTimeout) begin
        stop_run("Timeout waiting for ready_o to return high");
      end
      cycles++;
      @(negedge clk_i);
    end
  endtask

  task automatic load_value(input ctr_pkg::ctr_word_u v);
    @(posedge clk_i);
    #1;
    iv_i   = v;
    load_i = 1'b1;
    model_ctr = v;
    @(posedge clk_i);
    #1 load_i = 1'b0;
    @(negedge clk_i);
    check_word("ctr_o", ctr_o, model_ctr);
  endtask

  // One increment, checked against the model and the fixed latency
  task automatic incr_check();
    ctr_pkg::ctr_word_u exp;
    int                 busy;
    exp = model_incr(model_ctr);
    check_bit("ready_o", ready_o, 1'b1);
    @(posedge clk_i);
    #1 incr_mr_i = ctr_pkg::MrOn;
    @(posedge clk_i);
    #1 incr_mr_i = ctr_pkg::MrOff;
    wait_ready(busy);
    if (busy != IncrCycles) begin
      stop_run($sformatf("ERR ready_o low cycles got %h exp %h", busy, IncrCycles));
    end
    check_word("ctr_o", ctr_o, exp);
    check_bit("alert_o", alert_o, 1'b0);
    model_ctr = exp;
  endtask

  task automatic check_reset_values();
    ctr_pkg::ctr_word_u zero;
    zero.flat = '0;
    @(negedge clk_i);
    check_word("ctr_o", ctr_o, zero);
    check_bit("ready_o", ready_o, 1'b1);
    check_bit("alert_o", alert_o, 1'b0);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_load_incr();
    ctr_pkg::ctr_word_u v;
    v.flat = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    load_value(v);
    incr_check();
  endtask

  task automatic test_carry_ripple();
    ctr_pkg::ctr_word_u v;
    int                 k;
    int                 n;
    // Low k slices all ones, so the carry crosses k borders
    for (k = 1; k < ctr_pkg::NumSlices; k++) begin
      rand_word(v);
      for (n = 0; n < k; n++) begin
        v.slice[n] = 16'hffff;
      end
      load_value(v);
      incr_check();
    end
    for (n = 0; n < 20; n++) begin
      rand_word(v);
      load_value(v);
      incr_check();
      incr_check();
    end
  endtask

  task automatic test_wrap();
    ctr_pkg::ctr_word_u v;
    v.flat = '1;
    load_value(v);
    incr_check();
  endtask

  // Sticky alert and frozen counter after a fault
  task automatic check_stuck(input ctr_pkg::ctr_word_u held);
    repeat (12) begin
      @(negedge clk_i);
      check_bit("alert_o", alert_o, 1'b1);
      check_bit("ready_o", ready_o, 1'b0);
      check_word("ctr_o", ctr_o, held);
    end
  endtask

  task automatic test_rail_fault();
    ctr_pkg::ctr_word_u v;
    rand_word(v);
    load_value(v);
    @(posedge clk_i);
    #1 incr_mr_i = 2'b11;
    @(posedge clk_i);
    #1 incr_mr_i = ctr_pkg::MrOff;
    @(negedge clk_i);
    check_bit("alert_o", alert_o, 1'b1);
    // Later increment must not touch the counter
    @(posedge clk_i);
    #1 incr_mr_i = ctr_pkg::MrOn;
    @(posedge clk_i);
    #1 incr_mr_i = ctr_pkg::MrOff;
    check_stuck(v);
    reset_dut();
    check_reset_values();
    incr_check();
  endtask

  task automatic test_seq_fault();
    ctr_pkg::ctr_word_u v;
    rand_word(v);
    load_value(v);
    @(posedge clk_i);
    #1 incr_mr_i = ctr_pkg::MrOn;
    @(posedge clk_i);
    #1 incr_mr_i = ctr_pkg::MrOff;
    // Busy but still clean before the second request
    @(negedge clk_i);
    check_bit("ready_o", ready_o, 1'b0);
    check_bit("alert_o", alert_o, 1'b0);
    // Second request in the busy window
    repeat (2) @(posedge clk_i);
    #1 incr_mr_i = ctr_pkg::MrOn;
    @(posedge clk_i);
    #1 incr_mr_i = ctr_pkg::MrOff;
    repeat (12) begin
      @(negedge clk_i);
      check_bit("alert_o", alert_o, 1'b1);
      check_bit("ready_o", ready_o, 1'b0);
    end
    reset_dut();
    check_reset_values();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    seed      = 32'h4bd66d89;
    rst_ni    = 1'b0;
    incr_mr_i = ctr_pkg::MrOff;
    load_i    = 1'b0;
    iv_i.flat = '0;
    reset_dut();
    check_reset_values();
    test_load_incr();
    test_carry_ripple();
    test_wrap();
    test_rail_fault();
    test_seq_fault();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- ctr_incr.f
rtl/ctr_pkg.sv
rtl/ctr_req_check.sv
rtl/ctr_fsm.sv
rtl/ctr_state_reg.sv
rtl/ctr_top.sv
tb/tb_ctr_top.sv

//--- Makefile
# Verilator flow for the counter block
TOP  = tb_ctr_top
MDIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module ctr_top \
		rtl/ctr_pkg.sv rtl/ctr_req_check.sv rtl/ctr_fsm.sv \
		rtl/ctr_state_reg.sv rtl/ctr_top.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f ctr_incr.f -Mdir $(MDIR) -o V$(TOP)
	./$(MDIR)/V$(TOP)

clean:
	rm -rf $(MDIR)
